// File: compile.f
rtl/dma_pkg.sv
rtl/cmd_fifo.sv
rtl/burst_splitter.sv
rtl/stream_mover.sv
rtl/dma_stream.sv
tb/tb_bus_model.sv
tb/tb_dma_stream.sv

// File: rtl/burst_splitter.sv
`timescale 1ns/1ns

module burst_splitter #(
  parameter int ADDR_W     = 32,
  parameter int DATA_W     = 32,
  parameter int BOUNDARY_W = 12,
  parameter int MAX_BURST  = 256,
  parameter int BLEN_W     = 8
) (
  input  logic                CLK0,
  input  logic                RST0,
  input  logic                req_empty,
  output logic                req_deq,
  input  logic [ADDR_W-1:0]   req_addr,
  input  logic                req_to_core,
  input  logic                req_to_ext,
  input  logic [ADDR_W:0]     req_words,
  input  logic                issued_full,
  output logic                issued_enq,
  output dma_pkg::dma_dir_t   issued_dir,
  output logic [ADDR_W:0]     issued_words,
  output logic [ADDR_W-1:0]   araddr,
  output logic [BLEN_W-1:0]   arlen,
  output logic                arvalid,
  input  logic                arready,
  output logic [ADDR_W-1:0]   awaddr,
  output logic [BLEN_W-1:0]   awlen,
  output logic                awvalid,
  input  logic                awready,
  output logic                active
);

  localparam int OFF_W       = $clog2(DATA_W / 8);            // byte offset bits
  localparam int CNT_W       = ADDR_W + 1;
  localparam int BOUND_WORDS = 1 << (BOUNDARY_W - OFF_W);     // words per window
  localparam logic [ADDR_W-1:0] ADDR_MASK = {ADDR_W{1'b1}} << OFF_W;

  dma_pkg::burst_state_t state;
  dma_pkg::dma_dir_t     dir_q;
  dma_pkg::dma_dir_t     req_dir;
  logic [ADDR_W-1:0]     req_addr_al;
  logic [ADDR_W-1:0]     cur_addr;     // address of the burst in flight
  logic [CNT_W-1:0]      rem_words;    // words not yet accepted on the bus
  logic [CNT_W-1:0]      size_cap;
  logic [CNT_W-1:0]      rest_bound;
  logic [CNT_W-1:0]      burst_len;
  logic [CNT_W-1:0]      len_c;
  logic                  enq_pend;
  logic                  addr_done;

  function automatic logic [CNT_W-1:0] cap_words(input logic [CNT_W-1:0] w);
    cap_words = (w <= CNT_W'(MAX_BURST)) ? w : CNT_W'(MAX_BURST);
  endfunction

  // words left before the next boundary
  function automatic logic [CNT_W-1:0] rest_words(input logic [ADDR_W-1:0] a);
    rest_words = CNT_W'(BOUND_WORDS) - CNT_W'(a[BOUNDARY_W-1:OFF_W]);
  endfunction

  // last byte a burst reaches, from its channel address and length
  function automatic logic [ADDR_W-1:0] burst_last_byte(input logic [ADDR_W-1:0] a,
                                                         input logic [BLEN_W-1:0] len);
    burst_last_byte = a + ((ADDR_W'(len) + ADDR_W'(1)) << OFF_W) - ADDR_W'(1);
  endfunction

  assign req_addr_al = req_addr & ADDR_MASK;
  assign req_dir = req_to_ext  ? dma_pkg::DIR_TO_EXT  :
                   req_to_core ? dma_pkg::DIR_TO_CORE : dma_pkg::DIR_NONE;

  assign req_deq   = (state == dma_pkg::IDLE) && !req_empty && !issued_full;
  assign len_c     = (size_cap <= rest_bound) ? size_cap : rest_bound;
  assign addr_done = (arvalid && arready) || (awvalid && awready);

  // both address channels carry the same burst fields
  assign araddr = cur_addr;
  assign awaddr = cur_addr;
  assign arlen  = BLEN_W'(burst_len - 1'b1);
  assign awlen  = BLEN_W'(burst_len - 1'b1);

  assign issued_enq   = enq_pend;    // first WAIT cycle
  assign issued_dir   = dir_q;
  assign issued_words = burst_len;
  assign active       = (state != dma_pkg::IDLE);

  // -------------------------------------------------------------------------
  // splitter FSM
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      state    <= dma_pkg::IDLE;
      arvalid  <= 1'b0;
      awvalid  <= 1'b0;
      enq_pend <= 1'b0;
    end else begin
      enq_pend <= 1'b0;
      case (state)
        dma_pkg::IDLE: begin
          if (req_deq) state <= dma_pkg::LOAD;
        end
        dma_pkg::LOAD: begin  // queue head is valid now
          cur_addr   <= req_addr_al;
          rem_words  <= req_words;
          dir_q      <= req_dir;
          size_cap   <= cap_words(req_words);
          rest_bound <= rest_words(req_addr_al);
          if (req_words == '0 || req_dir == dma_pkg::DIR_NONE) begin
            state <= dma_pkg::IDLE;   // nothing to move
          end else begin
            state <= dma_pkg::ISSUE;
          end
        end
        dma_pkg::ISSUE: begin
          burst_len <= len_c;
          arvalid   <= (dir_q == dma_pkg::DIR_TO_CORE);
          awvalid   <= (dir_q == dma_pkg::DIR_TO_EXT);
          enq_pend  <= 1'b1;
          state     <= dma_pkg::WAIT;
        end
        dma_pkg::WAIT: begin
          if (addr_done) begin
            arvalid   <= 1'b0;
            awvalid   <= 1'b0;
            cur_addr  <= cur_addr + ADDR_W'(burst_len << OFF_W);
            rem_words <= rem_words - burst_len;
            if (rem_words == burst_len) begin
              state <= dma_pkg::IDLE;
            end else begin
              state <= dma_pkg::NEXT;
            end
          end
        end
        dma_pkg::NEXT: begin
          // hold here while the mover lags behind
          if (!issued_full) begin
            size_cap   <= cap_words(rem_words);
            rest_bound <= rest_words(cur_addr);
            state      <= dma_pkg::ISSUE;
          end
        end
        default: state <= dma_pkg::IDLE;
      endcase
    end
  end

  assert property (@(posedge CLK0) disable iff (RST0) !(arvalid && awvalid))
    else $error("burst_splitter: arvalid and awvalid high together");

  // first and last byte of a burst share one window
  assert property (@(posedge CLK0) disable iff (RST0)
    (!arvalid || (burst_last_byte(araddr, arlen) >> BOUNDARY_W) == (araddr >> BOUNDARY_W)) &&
    (!awvalid || (burst_last_byte(awaddr, awlen) >> BOUNDARY_W) == (awaddr >> BOUNDARY_W)))
    else $error("burst_splitter: burst crosses boundary");

endmodule

// File: rtl/cmd_fifo.sv
`timescale 1ns/1ns

module cmd_fifo #(
  parameter int DATA_BITS = 32,
  parameter int DEPTH_LOG = 4
) (
  input  logic                 CLK0,
  input  logic                 RST0,
  input  logic [DATA_BITS-1:0] wr_data,
  input  logic                 enq,
  output logic                 full,
  output logic                 almost_full,
  output logic [DATA_BITS-1:0] rd_data,
  input  logic                 deq,
  output logic                 empty
);

  localparam int DEPTH = 1 << DEPTH_LOG;
  localparam bit [DEPTH_LOG:0] CNT_FULL = (DEPTH_LOG + 1)'(DEPTH);
  localparam bit [DEPTH_LOG:0] CNT_ALMOST = (DEPTH_LOG + 1)'(DEPTH - 1);

  logic [DATA_BITS-1:0] mem [DEPTH];
  logic [DEPTH_LOG-1:0] head;
  logic [DEPTH_LOG-1:0] tail;
  logic [DEPTH_LOG:0]   count;
  logic [DEPTH_LOG:0]   count_nxt;
  logic                 do_enq;
  logic                 do_deq;

  assign do_enq = enq && !full;
  assign do_deq = deq && !empty;

  // occupancy after this cycle, so the flags see a simultaneous enq and deq
  always_comb begin
    case ({do_enq, do_deq})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  // -------------------------------------------------------------------------
  // pointers and registered flags
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      empty       <= 1'b1;
      full        <= 1'b0;
      almost_full <= 1'b0;
    end else begin
      if (do_enq) tail <= tail + 1'b1;   // wraps at DEPTH
      if (do_deq) head <= head + 1'b1;
      count       <= count_nxt;
      empty       <= (count_nxt == '0);
      full        <= (count_nxt == CNT_FULL);
      almost_full <= (count_nxt >= CNT_ALMOST);
    end
  end

  // head entry appears one cycle after deq
  always_ff @(posedge CLK0) begin
    if (do_enq) mem[tail] <= wr_data;
    rd_data <= mem[head];
  end

  // producers must watch full (or almost_full) before pushing
  assert property (@(posedge CLK0) disable iff (RST0) enq |-> !full)
    else $error("cmd_fifo: enq while full");

endmodule

// File: rtl/dma_pkg.sv
package dma_pkg;

  // -------------------------------------------------------------------------
  // default sizes for the top level parameters
  // -------------------------------------------------------------------------
  localparam int ADDR_W        = 32;   // external byte address
  localparam int DATA_W        = 32;   // power of two
  localparam int BOUNDARY_W    = 12;   // 4 KB burst window
  localparam int MAX_BURST     = 256;  // words per burst
  localparam int BLEN_W        = 8;    // awlen / arlen
  localparam int CMD_DEPTH_LOG = 4;    // both queues

  // -------------------------------------------------------------------------
  // splitter FSM and transfer direction
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    ISSUE,
    WAIT,
    NEXT
  } burst_state_t;

  // carried with every issued burst
  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_TO_CORE,   // external memory -> core stream
    DIR_TO_EXT     // core stream -> external memory
  } dma_dir_t;

endpackage

// File: rtl/dma_stream.sv
`timescale 1ns/1ns

module dma_stream #(
  parameter int ADDR_W        = dma_pkg::ADDR_W,
  parameter int DATA_W        = dma_pkg::DATA_W,
  parameter int BOUNDARY_W    = dma_pkg::BOUNDARY_W,
  parameter int MAX_BURST     = dma_pkg::MAX_BURST,
  parameter int BLEN_W        = dma_pkg::BLEN_W,
  parameter int CMD_DEPTH_LOG = dma_pkg::CMD_DEPTH_LOG
) (
  input  logic                CLK0,
  input  logic                RST0,
  // core stream
  output logic                core_rd_en,
  input  logic [DATA_W-1:0]   core_rd_data,
  input  logic                core_rd_empty,
  output logic                core_wr_en,
  output logic [DATA_W-1:0]   core_wr_data,
  input  logic                core_wr_almost_full,
  // requests
  input  logic [ADDR_W-1:0]   req_addr,     // byte address
  input  logic                req_to_core,
  input  logic                req_to_ext,
  input  logic [ADDR_W:0]     req_words,
  output logic                req_ready,
  output logic                req_busy,
  // external bus
  output logic [ADDR_W-1:0]   awaddr,
  output logic [BLEN_W-1:0]   awlen,
  output logic                awvalid,
  input  logic                awready,
  output logic [DATA_W-1:0]   wdata,
  output logic [DATA_W/8-1:0] wstrb,
  output logic                wlast,
  output logic                wvalid,
  input  logic                wready,
  output logic [ADDR_W-1:0]   araddr,
  output logic [BLEN_W-1:0]   arlen,
  output logic                arvalid,
  input  logic                arready,
  input  logic [DATA_W-1:0]   rdata,
  input  logic                rvalid,
  output logic                rready
);

  localparam int CNT_W = ADDR_W + 1;
  localparam int REQ_W = ADDR_W + 2 + CNT_W;
  localparam int ISS_W = $bits(dma_pkg::dma_dir_t) + CNT_W;

  logic              req_enq;
  logic              req_deq;
  logic              req_empty;
  logic              req_almost_full;
  logic [REQ_W-1:0]  req_rd_data;
  logic [ADDR_W-1:0] hd_addr;
  logic              hd_to_core;
  logic              hd_to_ext;
  logic [CNT_W-1:0]  hd_words;

  logic              issued_enq;
  logic              issued_deq;
  logic              issued_full;
  logic              issued_empty;
  dma_pkg::dma_dir_t tl_dir;
  logic [CNT_W-1:0]  tl_words;
  logic [ISS_W-1:0]  issued_rd_data;
  dma_pkg::dma_dir_t hd_dir;
  logic [CNT_W-1:0]  hd_burst_words;

  logic              split_active;
  logic              move_active;

  // -------------------------------------------------------------------------
  // request queue
  // -------------------------------------------------------------------------
  assign req_enq   = req_to_core || req_to_ext;
  assign req_ready = !req_almost_full;
  assign {hd_addr, hd_to_core, hd_to_ext, hd_words} = req_rd_data;

  cmd_fifo #(
    .DATA_BITS (REQ_W),
    .DEPTH_LOG (CMD_DEPTH_LOG)
  ) req_fifo_i (
    .CLK0        (CLK0),
    .RST0        (RST0),
    .wr_data     ({req_addr, req_to_core, req_to_ext, req_words}),
    .enq         (req_enq),
    .full        (),
    .almost_full (req_almost_full),
    .rd_data     (req_rd_data),
    .deq         (req_deq),
    .empty       (req_empty)
  );

  // -------------------------------------------------------------------------
  // issued-burst queue
  // -------------------------------------------------------------------------
  assign hd_dir         = dma_pkg::dma_dir_t'(issued_rd_data[ISS_W-1:CNT_W]);
  assign hd_burst_words = issued_rd_data[CNT_W-1:0];

  cmd_fifo #(
    .DATA_BITS (ISS_W),
    .DEPTH_LOG (CMD_DEPTH_LOG)
  ) issued_fifo_i (
    .CLK0        (CLK0),
    .RST0        (RST0),
    .wr_data     ({tl_dir, tl_words}),
    .enq         (issued_enq),
    .full        (issued_full),
    .almost_full (),
    .rd_data     (issued_rd_data),
    .deq         (issued_deq),
    .empty       (issued_empty)
  );

  burst_splitter #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .BOUNDARY_W (BOUNDARY_W),
    .MAX_BURST  (MAX_BURST),
    .BLEN_W     (BLEN_W)
  ) burst_splitter_i (
    .CLK0         (CLK0),
    .RST0         (RST0),
    .req_empty    (req_empty),
    .req_deq      (req_deq),
    .req_addr     (hd_addr),
    .req_to_core  (hd_to_core),
    .req_to_ext   (hd_to_ext),
    .req_words    (hd_words),
    .issued_full  (issued_full),
    .issued_enq   (issued_enq),
    .issued_dir   (tl_dir),
    .issued_words (tl_words),
    .araddr       (araddr),
    .arlen        (arlen),
    .arvalid      (arvalid),
    .arready      (arready),
    .awaddr       (awaddr),
    .awlen        (awlen),
    .awvalid      (awvalid),
    .awready      (awready),
    .active       (split_active)
  );

  stream_mover #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) stream_mover_i (
    .CLK0                (CLK0),
    .RST0                (RST0),
    .issued_empty        (issued_empty),
    .issued_deq          (issued_deq),
    .issued_dir          (hd_dir),
    .issued_words        (hd_burst_words),
    .core_rd_en          (core_rd_en),
    .core_rd_data        (core_rd_data),
    .core_rd_empty       (core_rd_empty),
    .core_wr_en          (core_wr_en),
    .core_wr_data        (core_wr_data),
    .core_wr_almost_full (core_wr_almost_full),
    .wdata               (wdata),
    .wstrb               (wstrb),
    .wlast               (wlast),
    .wvalid              (wvalid),
    .wready              (wready),
    .rdata               (rdata),
    .rvalid              (rvalid),
    .rready              (rready),
    .active              (move_active)
  );

  // busy from the cycle after enqueue until everything drains
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      req_busy <= 1'b0;
    end else begin
      req_busy <= req_enq || !req_empty || !issued_empty ||
                  split_active || move_active;
    end
  end

endmodule

// File: rtl/stream_mover.sv
`timescale 1ns/1ns

module stream_mover #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 32
) (
  input  logic                  CLK0,
  input  logic                  RST0,
  input  logic                  issued_empty,
  output logic                  issued_deq,
  input  dma_pkg::dma_dir_t     issued_dir,
  input  logic [ADDR_W:0]       issued_words,
  output logic                  core_rd_en,
  input  logic [DATA_W-1:0]     core_rd_data,
  input  logic                  core_rd_empty,
  output logic                  core_wr_en,
  output logic [DATA_W-1:0]     core_wr_data,
  input  logic                  core_wr_almost_full,
  output logic [DATA_W-1:0]     wdata,
  output logic [DATA_W/8-1:0]   wstrb,
  output logic                  wlast,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic [DATA_W-1:0]     rdata,
  input  logic                  rvalid,
  output logic                  rready,
  output logic                  active
);

  localparam int CNT_W = ADDR_W + 1;

  dma_pkg::dma_dir_t mode;        // DIR_NONE while idle
  logic [CNT_W-1:0]  beats;       // words left to pull or receive
  logic              deq_q;       // issued entry valid this cycle
  logic              rd_en_q;     // core word arrives this cycle
  logic [DATA_W-1:0] wdata_hold;

  assign issued_deq = !issued_empty && !deq_q && (mode == dma_pkg::DIR_NONE);
  assign active     = (mode != dma_pkg::DIR_NONE) || deq_q;

  // -------------------------------------------------------------------------
  // external -> core
  // -------------------------------------------------------------------------
  assign rready       = (mode == dma_pkg::DIR_TO_CORE) && !core_wr_almost_full;
  assign core_wr_en   = rvalid && rready;
  assign core_wr_data = rdata;

  // -------------------------------------------------------------------------
  // core -> external
  // -------------------------------------------------------------------------
  // pull a word only if the w slot frees up this cycle
  assign core_rd_en = (mode == dma_pkg::DIR_TO_EXT) && (beats != '0) &&
                      !core_rd_empty && (!wvalid || wready);

  assign wdata = rd_en_q ? core_rd_data : wdata_hold;
  assign wstrb = '1;
  assign wlast = (mode == dma_pkg::DIR_TO_EXT) && (beats == '0);  // last word pulled

  always_ff @(posedge CLK0) begin
    wdata_hold <= wdata;
  end

  always_ff @(posedge CLK0) begin
    if (RST0) begin
      mode    <= dma_pkg::DIR_NONE;
      deq_q   <= 1'b0;
      rd_en_q <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      deq_q   <= issued_deq;
      rd_en_q <= core_rd_en;
      wvalid  <= core_rd_en || (wvalid && !wready);
      case (mode)
        dma_pkg::DIR_NONE: begin
          if (deq_q) begin
            mode  <= issued_dir;
            beats <= issued_words;
          end
        end
        dma_pkg::DIR_TO_CORE: begin
          if (core_wr_en) begin
            beats <= beats - 1'b1;
            if (beats == CNT_W'(1)) mode <= dma_pkg::DIR_NONE;
          end
        end
        dma_pkg::DIR_TO_EXT: begin
          if (core_rd_en) beats <= beats - 1'b1;
          if (wvalid && wready && wlast) mode <= dma_pkg::DIR_NONE;
        end
        default: mode <= dma_pkg::DIR_NONE;
      endcase
    end
  end

  // a stalled w beat keeps both valid and payload
  assert property (@(posedge CLK0) disable iff (RST0)
    (wvalid && !wready) |=> (wvalid && $stable(wdata)))
    else $error("stream_mover: w beat dropped or changed under stall");

endmodule

// File: tb/tb_bus_model.sv
`timescale 1ns/1ns

module tb_bus_model #(
  parameter logic [31:0] SRC_BASE = 32'hC000_0000
) (
  input  logic        CLK0,
  input  logic        RST0,
  input  logic        stall_en,      // random stalls on both directions
  input  logic        ar_hold,       // keep arready low
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic        rvalid,
  input  logic        rready,
  input  logic [31:0] awaddr,
  input  logic [7:0]  awlen,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic        wvalid,
  output logic        wready,
  input  logic        core_rd_en,
  output logic [31:0] core_rd_data,
  output logic        core_rd_empty,
  input  logic        core_wr_en,
  input  logic [31:0] core_wr_data,
  output logic        core_wr_almost_full
);

  logic [31:0] mem [0:8191];         // 32 KB window where word i holds i
  logic [31:0] sink_log [0:2047];
  logic [31:0] ar_addr_a [0:63];
  logic [7:0]  ar_len_a [0:63];
  logic [31:0] aw_addr_a [0:63];
  logic [7:0]  aw_len_a [0:63];
  logic [5:0]  ar_wr;
  logic [5:0]  ar_rd;
  logic [5:0]  aw_wr;
  logic [5:0]  aw_rd;
  int          r_beat;
  int          w_beat;
  int          src_cnt;
  int          sink_cnt;
  int          seed;

  initial begin
    seed = 48;
    for (int i = 0; i < 8192; i++) mem[i] = 32'(i);
    arready             = 1'b0;
    awready             = 1'b0;
    wready              = 1'b0;
    rvalid              = 1'b0;
    rdata               = '0;
    core_rd_data        = '0;
    core_rd_empty       = 1'b0;
    core_wr_almost_full = 1'b0;
  end

  // one process draws every random number, so the sequence is fixed
  always @(posedge CLK0) begin
    if (RST0) begin
      arready             <= 1'b0;
      awready             <= 1'b0;
      wready              <= 1'b0;
      rvalid              <= 1'b0;
      core_rd_empty       <= 1'b0;
      core_wr_almost_full <= 1'b0;
      ar_wr = '0;
      ar_rd = '0;
      aw_wr = '0;
      aw_rd = '0;
      r_beat = 0;
      w_beat = 0;
      src_cnt = 0;
      sink_cnt = 0;
    end else begin
      if (arvalid && arready) begin
        ar_addr_a[ar_wr] = araddr;
        ar_len_a[ar_wr]  = arlen;
        ar_wr            = ar_wr + 1'b1;
      end
      if (awvalid && awready) begin
        aw_addr_a[aw_wr] = awaddr;
        aw_len_a[aw_wr]  = awlen;
        aw_wr            = aw_wr + 1'b1;
      end

      // -----------------------------------------------------------------------
      // read data held until rready
      // -----------------------------------------------------------------------
      if (rvalid && rready) begin
        if (r_beat == int'(ar_len_a[ar_rd])) begin
          r_beat = 0;
          ar_rd  = ar_rd + 1'b1;
        end else begin
          r_beat = r_beat + 1;
        end
      end
      if (!rvalid || rready) begin
        rvalid <= (ar_wr != ar_rd) && (!stall_en || (($random(seed) & 3) != 0));
        rdata  <= mem[13'((ar_addr_a[ar_rd] >> 2) + 32'(r_beat))];
      end

      // wready waits for an accepted address
      if (wvalid && wready) begin
        mem[13'((aw_addr_a[aw_rd] >> 2) + 32'(w_beat))] = wdata;
        if (w_beat == int'(aw_len_a[aw_rd])) begin
          w_beat = 0;
          aw_rd  = aw_rd + 1'b1;
        end else begin
          w_beat = w_beat + 1;
        end
      end
      wready  <= (aw_wr != aw_rd) && (!stall_en || (($random(seed) & 3) != 0));
      arready <= !ar_hold && (!stall_en || (($random(seed) & 3) != 0));
      awready <= !stall_en || (($random(seed) & 3) != 0);

      // core source counter and sink log
      if (core_rd_en) begin
        core_rd_data <= SRC_BASE + 32'(src_cnt);   // word shows up next cycle
        src_cnt = src_cnt + 1;
      end
      if (core_wr_en) begin
        sink_log[sink_cnt % 2048] = core_wr_data;
        sink_cnt = sink_cnt + 1;
      end
      core_rd_empty       <= stall_en && (($random(seed) & 3) == 0);
      core_wr_almost_full <= stall_en && (($random(seed) & 7) == 0);
    end
  end

endmodule

// File: tb/tb_dma_stream.sv
`timescale 1ns/1ns

module tb_dma_stream;

  localparam logic [31:0] SRC_BASE   = 32'hC000_0000;
  localparam int          TEST_WORDS = 20 + 20 + 600 + 360 + 5 + 96;  // all tests
  localparam int          WATCHDOG   = 4 * TEST_WORDS * 20;

  logic        CLK0 = 1'b0;
  logic        RST0;
  logic        core_rd_en;
  logic [31:0] core_rd_data;
  logic        core_rd_empty;
  logic        core_wr_en;
  logic [31:0] core_wr_data;
  logic        core_wr_almost_full;
  logic [31:0] req_addr;
  logic        req_to_core;
  logic        req_to_ext;
  logic [32:0] req_words;
  logic        req_ready;
  logic        req_busy;
  logic [31:0] awaddr;
  logic [7:0]  awlen;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [31:0] araddr;
  logic [7:0]  arlen;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic        rvalid;
  logic        rready;
  logic        stall_en;
  logic        ar_hold;
  logic        w_last_exp;

  // expected address beats, read words and write word addresses, in order
  logic [31:0] exp_ab_addr [0:127];
  int          exp_ab_len [0:127];
  logic        exp_ab_ext [0:127];
  int          exp_wb_len [0:127];   // write bursts only
  logic [31:0] exp_rx [0:2047];
  int          exp_wr_word [0:255];
  int          ab_total = 0;
  int          wb_total = 0;
  int          rx_total = 0;
  int          tx_total = 0;
  int          ab_idx = 0;
  int          wb_idx = 0;
  int          wb_beat = 0;
  int          rx_idx = 0;
  int          tx_idx = 0;
  int          errors = 0;
  int          err_start;
  int          rx_start;
  int          tx_start;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name = "reset";

  logic        addr_acc;
  logic [40:0] acc_act;
  logic [40:0] acc_exp;
  logic [31:0] exp_rx_word;
  logic [31:0] exp_tx_word;

  assign addr_acc    = (arvalid && arready) || (awvalid && awready);
  assign acc_act     = awvalid ? {1'b1, awaddr, awlen} : {1'b0, araddr, arlen};
  assign acc_exp     = {exp_ab_ext[ab_idx], exp_ab_addr[ab_idx], 8'(exp_ab_len[ab_idx] - 1)};
  assign exp_rx_word = exp_rx[rx_idx];
  assign exp_tx_word = SRC_BASE + 32'(tx_idx);
  assign w_last_exp  = (wb_beat == exp_wb_len[wb_idx] - 1);   // final beat of its burst

  always #5 CLK0 = ~CLK0;

  dma_stream dma_stream_i (.*);

  tb_bus_model #(.SRC_BASE(SRC_BASE)) bus_i (.*);

  always @(posedge CLK0) begin
    if (core_wr_en) rx_idx <= rx_idx + 1;
    if (wvalid && wready) begin
      tx_idx <= tx_idx + 1;
      if (w_last_exp) begin
        wb_beat <= 0;
        wb_idx  <= wb_idx + 1;
      end else begin
        wb_beat <= wb_beat + 1;
      end
    end
    if (addr_acc) ab_idx <= ab_idx + 1;
  end

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  assert property (@(posedge CLK0) RST0 |=> (!arvalid && !awvalid && !wvalid && !rready &&
                   !core_rd_en && !core_wr_en && !req_busy && req_ready))
    else begin
      $display("control outputs are not idle after reset");
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0) addr_acc |-> (acc_act == acc_exp))
    else begin
      $display("ERR %s address beat {ext,addr,len}: expected %h actual %h", test_name,
               $sampled(acc_exp), $sampled(acc_act));
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0)
                   core_wr_en |-> (core_wr_data == exp_rx_word))
    else begin
      $display("ERR %s core word: expected %h actual %h", test_name,
               $sampled(exp_rx_word), $sampled(core_wr_data));
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0)
                   (wvalid && wready) |-> (wdata == exp_tx_word && wlast == w_last_exp))
    else begin
      $display("ERR %s w beat {wlast,wdata}: expected %h actual %h", test_name,
               $sampled({w_last_exp, exp_tx_word}), $sampled({wlast, wdata}));
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0) wvalid |-> (wstrb == 4'hf))
    else begin
      $display("ERR %s wstrb: expected f actual %h", test_name, $sampled(wstrb));
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0) !(arvalid && awvalid))
    else begin
      $display("%s: arvalid and awvalid were high in the same cycle", test_name);
      errors++;
    end

  assert property (@(posedge CLK0) disable iff (RST0)
                   (arvalid || awvalid || wvalid || rready) |-> req_busy)
    else begin
      $display("%s: req_busy low while a transfer is in progress", test_name);
      errors++;
    end

  // ---------------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------------
  // bursts capped at 256 words and cut at each 4 KB line
  task automatic expect_request(input logic [31:0] addr, input logic ext, input int words);
    logic [31:0] a;
    int          rem;
    int          len;
    int          room;
    a   = addr & 32'hFFFF_FFFC;
    rem = words;
    while (rem > 0) begin
      room = (4096 - int'(a[11:0])) / 4;
      len  = (rem < 256) ? rem : 256;
      if (len > room) len = room;
      exp_ab_addr[ab_total] = a;
      exp_ab_len[ab_total]  = len;
      exp_ab_ext[ab_total]  = ext;
      ab_total = ab_total + 1;
      if (ext) begin
        exp_wb_len[wb_total] = len;
        wb_total = wb_total + 1;
      end
      a   = a + 32'(len * 4);
      rem = rem - len;
    end
    for (int i = 0; i < words; i++) begin
      if (ext) begin
        exp_wr_word[tx_total] = int'(addr >> 2) + i;
        tx_total = tx_total + 1;
      end else begin
        exp_rx[rx_total] = (addr >> 2) + 32'(i);   // memory word = its word address
        rx_total = rx_total + 1;
      end
    end
  endtask

  task automatic send_request(input logic [31:0] addr, input logic ext, input int words);
    expect_request(addr, ext, words);
    @(posedge CLK0);
    while (!req_ready) @(posedge CLK0);
    req_addr    <= addr;
    req_to_core <= !ext;
    req_to_ext  <= ext;
    req_words   <= 33'(words);
    @(posedge CLK0);
    req_to_core <= 1'b0;
    req_to_ext  <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
    rx_start  = rx_total;
    tx_start  = tx_total;
  endtask

  // busy rises the cycle after enqueue, so it is seen high before it falls
  task automatic end_test();
    @(posedge CLK0);
    while (!req_busy) @(posedge CLK0);
    while (req_busy) @(posedge CLK0);
    assert (ab_idx == ab_total) else begin
      $display("ERR %s address beats: expected %0d actual %0d", test_name, ab_total, ab_idx);
      errors++;
    end
    assert (rx_idx == rx_total) else begin
      $display("ERR %s core words: expected %0d actual %0d", test_name, rx_total, rx_idx);
      errors++;
    end
    assert (tx_idx == tx_total) else begin
      $display("ERR %s w beats: expected %0d actual %0d", test_name, tx_total, tx_idx);
      errors++;
    end
    // core sink keeps every delivered word in arrival order
    for (int k = rx_start; k < rx_total; k++) begin
      assert (bus_i.sink_log[k % 2048] == exp_rx[k]) else begin
        $display("ERR %s sink word %0d: expected %h actual %h", test_name, k,
                 exp_rx[k], bus_i.sink_log[k % 2048]);
        errors++;
      end
    end
    for (int k = tx_start; k < tx_total; k++) begin
      assert (bus_i.mem[exp_wr_word[k]] == SRC_BASE + 32'(k)) else begin
        $display("ERR %s memory word %0h: expected %h actual %h", test_name, exp_wr_word[k],
                 SRC_BASE + 32'(k), bus_i.mem[exp_wr_word[k]]);
        errors++;
      end
    end
    tests_run = tests_run + 1;
    if (errors != err_start) tests_failed = tests_failed + 1;
    $display("test %-16s %s", test_name, (errors == err_start) ? "ok" : "failed");
  endtask

  initial begin
    repeat (WATCHDOG) @(posedge CLK0);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int n;
    RST0                = 1'b1;
    req_addr            = '0;
    req_to_core         = 1'b0;
    req_to_ext          = 1'b0;
    req_words           = '0;
    stall_en            = 1'b0;
    ar_hold             = 1'b0;
    repeat (4) @(posedge CLK0);
    RST0 <= 1'b0;

    start_test("to_core_20");
    send_request(32'h0000_0100, 1'b0, 20);
    end_test();

    start_test("to_ext_20");
    send_request(32'h0000_2000, 1'b1, 20);
    end_test();

    start_test("boundary_600");   // 40 + 256 + 256 + 48
    send_request(32'h0000_0F60, 1'b0, 600);
    end_test();

    start_test("random_stalls");
    stall_en <= 1'b1;
    send_request(32'h0000_3F00, 1'b0, 150);
    send_request(32'h0000_5000, 1'b1, 100);
    send_request(32'h0000_0800, 1'b0, 70);
    send_request(32'h0000_6FF0, 1'b1, 40);
    end_test();
    stall_en <= 1'b0;

    start_test("zero_misaligned");
    send_request(32'h0000_0400, 1'b0, 0);
    send_request(32'h0000_0203, 1'b0, 5);
    end_test();

    // queue fills behind a stuck read address
    start_test("ar_backpressure");
    ar_hold <= 1'b1;
    n = 0;
    @(posedge CLK0);
    while (req_ready && n < 24) begin
      send_request(32'h0000_0C00 + 32'(n * 16), 1'b0, 4);
      n = n + 1;
      @(posedge CLK0);
    end
    assert (!req_ready) else begin
      $display("%s: req_ready stayed high after %0d requests with arready low", test_name, n);
      errors++;
    end
    ar_hold <= 1'b0;
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
